// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/mul_pkg.sv
      - rtl/mul_ctrl.sv
      - rtl/mul_pprod.sv
      - rtl/mul_accum.sv
      - rtl/mul_unit_top.sv
  - target: simulation
    files:
      - sim/tb_mul_unit.sv

// ==== rtl/mul_accum.sv ====
`include "mul_settings.svh"

module mul_accum (
  input  mul_pkg::pprod_t pp_ll,
  input  mul_pkg::pprod_t pp_lh,
  input  mul_pkg::pprod_t pp_hl,
  input  mul_pkg::pprod_t pp_hh,
  input  logic            sel_hi,
  input  logic            word,
  output mul_pkg::xlen_t  result
);

  mul_pkg::wide_t ll_ext;
  mul_pkg::wide_t lh_ext;
  mul_pkg::wide_t hl_ext;
  mul_pkg::wide_t hh_ext;
  mul_pkg::wide_t sum;

  // ll has a zero top bit in both parts, plain zero-extend
  assign ll_ext = {{(`MUL_WIDE_W - `MUL_PP_W){1'b0}}, pp_ll};

  // cross terms sit at bit 32 and keep their sign
  assign lh_ext = {
    {(`MUL_WIDE_W - `MUL_PP_W - `MUL_HALF){pp_lh[`MUL_PP_W-1]}},
    pp_lh,
    {`MUL_HALF{1'b0}}
  };
  assign hl_ext = {
    {(`MUL_WIDE_W - `MUL_PP_W - `MUL_HALF){pp_hl[`MUL_PP_W-1]}},
    pp_hl,
    {`MUL_HALF{1'b0}}
  };

  // hh fills the top exactly, no extension left
  assign hh_ext = {pp_hh, {`MUL_XLEN{1'b0}}};

  // bits above 127 wrap, only 127:0 are used
  assign sum = ll_ext + lh_ext + hl_ext + hh_ext;

  always_comb begin
    if (sel_hi) begin
      result = sum[2*`MUL_XLEN-1:`MUL_XLEN];
    end else if (word) begin
      // MULW, sign-extend the low word
      result = {{(`MUL_XLEN - `MUL_HALF){sum[`MUL_HALF-1]}}, sum[`MUL_HALF-1:0]};
    end else begin
      result = sum[`MUL_XLEN-1:0];
    end
  end

  // word only comes with MUL, so it never meets sel_hi
  always_comb begin
    a_sel_excl: assert final (!(sel_hi && word))
      else $error("sel_hi and word both set");
  end

endmodule

// ==== rtl/mul_ctrl.sv ====
module mul_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             flush,
  input  mul_pkg::mul_fn_t op,
  input  logic             word,
  input  mul_pkg::tag_t    tag,
  output logic             load,
  output logic             a_signed,
  output logic             b_signed,
  output logic             sel_hi_q,
  output logic             word_q,
  output logic             out_valid,
  output mul_pkg::tag_t    out_tag
);

  mul_pkg::stg_state_e state_q;
  mul_pkg::stg_state_e state_d;
  logic                sel_hi;    // decoded, not yet registered

  // no back-pressure, the stage empties every cycle
  assign load = in_valid & ~flush;

  // operand signedness and result half from the op code
  always_comb begin
    a_signed = 1'b1;
    b_signed = 1'b0;
    sel_hi   = 1'b1;
    case (op)
      mul_pkg::FN_MUL: begin
        // low 64 bits do not depend on signedness
        sel_hi = 1'b0;
      end
      mul_pkg::FN_MULH: begin
        b_signed = 1'b1;
      end
      mul_pkg::FN_MULHSU: begin
        b_signed = 1'b0;          // rs2 unsigned
      end
      mul_pkg::FN_MULHU: begin
        a_signed = 1'b0;
      end
      default: begin
        sel_hi = 1'b0;
      end
    endcase
  end

  // stage occupancy
  always_comb begin
    state_d = state_q;
    case (state_q)
      mul_pkg::STG_EMPTY: begin
        if (load) begin
          state_d = mul_pkg::STG_FULL;
        end
      end
      mul_pkg::STG_FULL: begin
        // result leaves this cycle; refill only on a new accept
        // flush blocks load, so a flushed stage drains here too
        if (!load) begin
          state_d = mul_pkg::STG_EMPTY;
        end
      end
      default: begin
        state_d = mul_pkg::STG_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= mul_pkg::STG_EMPTY;
      sel_hi_q <= 1'b0;
      word_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load) begin
        sel_hi_q <= sel_hi;
        word_q   <= word;   // only meaningful with MUL, gives MULW
      end
    end
  end

  // tag is payload, follows the partial products
  always_ff @(posedge clk) begin
    if (load) begin
      out_tag <= tag;
    end
  end

  // flush kills the op presented this cycle
  assign out_valid = (state_q == mul_pkg::STG_FULL) & ~flush;

  // word is a MUL modifier only
  a_word_only_mul: assert property (
    @(posedge clk) disable iff (!rst_n)
    load |-> (!word || op == mul_pkg::FN_MUL)
  ) else $error("word set on a non-MUL op");

  // every result is one cycle behind its acceptance
  a_valid_after_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(load)
  ) else $error("out_valid without acceptance one cycle earlier");

endmodule

// ==== rtl/mul_pkg.sv ====
`include "mul_settings.svh"

package mul_pkg;

  // full-width operand or result
  typedef logic [`MUL_XLEN-1:0] xlen_t;

  // one half of an operand with its extension bit on top
  typedef logic [`MUL_PART_W-1:0] part_t;

  // signed product of two parts
  typedef logic [`MUL_PP_W-1:0] pprod_t;

  // alignment and sum vector for the second stage
  typedef logic [`MUL_WIDE_W-1:0] wide_t;

  // destination tag
  typedef logic [`MUL_TAG_W-1:0] tag_t;

  // op code, low two bits of funct3
  typedef logic [1:0] mul_fn_t;

  localparam mul_fn_t FN_MUL    = 2'd0;
  localparam mul_fn_t FN_MULH   = 2'd1;
  localparam mul_fn_t FN_MULHSU = 2'd2;
  localparam mul_fn_t FN_MULHU  = 2'd3;

  // occupancy of the partial-product stage
  typedef enum logic {
    STG_EMPTY,
    STG_FULL
  } stg_state_e;

endpackage

// ==== rtl/mul_pprod.sv ====
`include "mul_settings.svh"

module mul_pprod (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load,
  input  logic            a_signed,
  input  logic            b_signed,
  input  mul_pkg::xlen_t  operand_a,
  input  mul_pkg::xlen_t  operand_b,
  output mul_pkg::pprod_t pp_ll,
  output mul_pkg::pprod_t pp_lh,
  output mul_pkg::pprod_t pp_hl,
  output mul_pkg::pprod_t pp_hh
);

  mul_pkg::part_t  a_lo;
  mul_pkg::part_t  a_hi;
  mul_pkg::part_t  b_lo;
  mul_pkg::part_t  b_hi;

  mul_pkg::pprod_t ll_d;
  mul_pkg::pprod_t lh_d;
  mul_pkg::pprod_t hl_d;
  mul_pkg::pprod_t hh_d;

  // low halves are always unsigned, zero on top
  assign a_lo = {1'b0, operand_a[`MUL_HALF-1:0]};
  assign b_lo = {1'b0, operand_b[`MUL_HALF-1:0]};

  // high halves carry the operand sign if the op wants it
  assign a_hi = {a_signed & operand_a[`MUL_XLEN-1], operand_a[`MUL_XLEN-1:`MUL_HALF]};
  assign b_hi = {b_signed & operand_b[`MUL_XLEN-1], operand_b[`MUL_XLEN-1:`MUL_HALF]};

  // 33x33 signed products, result width holds the full product
  assign ll_d = $signed(a_lo) * $signed(b_lo);
  assign lh_d = $signed(a_lo) * $signed(b_hi);
  assign hl_d = $signed(a_hi) * $signed(b_lo);
  assign hh_d = $signed(a_hi) * $signed(b_hi);

  // stage registers, written only on accept
  always_ff @(posedge clk) begin
    if (load) begin
      pp_ll <= ll_d;
      pp_lh <= lh_d;
      pp_hl <= hl_d;
      pp_hh <= hh_d;
    end
  end

  // an X on load would corrupt the products silently
  a_load_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(load)
  ) else $error("load is unknown");

endmodule

// ==== rtl/mul_settings.svh ====
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// operand and result width
`define MUL_XLEN 64

// each operand is split into two halves of this width
`define MUL_HALF 32

// destination register tag carried alongside each op
`define MUL_TAG_W 5

// derived widths for the datapath
`define MUL_PART_W (`MUL_HALF + 1)         // half plus sign-extension bit
`define MUL_PP_W   (2 * `MUL_PART_W)       // 33x33 signed product
`define MUL_WIDE_W (2 * `MUL_XLEN + 2)     // accumulator, two guard bits

`endif

// ==== rtl/mul_unit_top.sv ====
module mul_unit_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             flush,
  input  mul_pkg::mul_fn_t op,
  input  logic             word,
  input  mul_pkg::tag_t    tag,
  input  mul_pkg::xlen_t   operand_a,
  input  mul_pkg::xlen_t   operand_b,
  output logic             out_valid,
  output mul_pkg::tag_t    out_tag,
  output mul_pkg::xlen_t   result
);

  logic            load;
  logic            a_signed;
  logic            b_signed;
  logic            sel_hi_q;
  logic            word_q;

  // registered partial products between the stages
  mul_pkg::pprod_t pp_ll;
  mul_pkg::pprod_t pp_lh;
  mul_pkg::pprod_t pp_hl;
  mul_pkg::pprod_t pp_hh;

  mul_ctrl i_mul_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .flush     (flush),
    .op        (op),
    .word      (word),
    .tag       (tag),
    .load      (load),
    .a_signed  (a_signed),
    .b_signed  (b_signed),
    .sel_hi_q  (sel_hi_q),
    .word_q    (word_q),
    .out_valid (out_valid),
    .out_tag   (out_tag)
  );

  // first stage
  mul_pprod i_mul_pprod (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .a_signed  (a_signed),
    .b_signed  (b_signed),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh)
  );

  // second stage, combinational from the stage registers
  mul_accum i_mul_accum (
    .pp_ll  (pp_ll),
    .pp_lh  (pp_lh),
    .pp_hl  (pp_hl),
    .pp_hh  (pp_hh),
    .sel_hi (sel_hi_q),
    .word   (word_q),
    .result (result)
  );

endmodule

// ==== sim/tb_mul_unit.sv ====
`include "mul_settings.svh"

module tb_mul_unit;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CYCLES     = 2000;
  localparam int RESET_CYCLES   = 4;
  localparam int DRAIN_CYCLES   = 3;
  // stimulus run plus room for reset and drain
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             flush;
  mul_pkg::mul_fn_t op;
  logic             word;
  mul_pkg::tag_t    tag;
  mul_pkg::xlen_t   operand_a;
  mul_pkg::xlen_t   operand_b;
  logic             out_valid;
  mul_pkg::tag_t    out_tag;
  mul_pkg::xlen_t   result;

  // one-deep scoreboard slot since the stage holds at most one op
  logic             pend_valid;
  mul_pkg::tag_t    pend_tag;
  mul_pkg::xlen_t   pend_result;

  int               errors;
  int               results_seen;
  int               offers_flushed;
  int               results_killed;
  int               cycle_count;

  mul_unit_top i_mul_unit_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .flush     (flush),
    .op        (op),
    .word      (word),
    .tag       (tag),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .out_valid (out_valid),
    .out_tag   (out_tag),
    .result    (result)
  );

  always #4 clk = ~clk;   // 8 ns period

  // full 128-bit product from operands widened to 129 bits
  function automatic mul_pkg::xlen_t model_result(input mul_pkg::mul_fn_t fn, input logic w,
                                                  input mul_pkg::xlen_t a,
                                                  input mul_pkg::xlen_t b);
    logic signed [2*`MUL_XLEN:0] ea;
    logic signed [2*`MUL_XLEN:0] eb;
    logic signed [2*`MUL_XLEN:0] prod;
    logic                        a_sgn;
    logic                        b_sgn;
    a_sgn = (fn == mul_pkg::FN_MULH) || (fn == mul_pkg::FN_MULHSU);
    b_sgn = (fn == mul_pkg::FN_MULH);
    ea = a_sgn ? {{(`MUL_XLEN+1){a[`MUL_XLEN-1]}}, a} : {{(`MUL_XLEN+1){1'b0}}, a};
    eb = b_sgn ? {{(`MUL_XLEN+1){b[`MUL_XLEN-1]}}, b} : {{(`MUL_XLEN+1){1'b0}}, b};
    prod = ea * eb;
    if (fn != mul_pkg::FN_MUL) begin
      model_result = prod[2*`MUL_XLEN-1:`MUL_XLEN];
    end else if (w) begin
      model_result = {{(`MUL_XLEN-32){prod[31]}}, prod[31:0]};   // MULW
    end else begin
      model_result = prod[`MUL_XLEN-1:0];
    end
  endfunction

  // corner values now and then and random ones otherwise
  function automatic mul_pkg::xlen_t pick_operand();
    int unsigned r;
    r = $urandom % 8;
    case (r)
      0: pick_operand = '0;
      1: pick_operand = '1;
      2: pick_operand = {1'b1, {(`MUL_XLEN-1){1'b0}}};
      default: pick_operand = {$urandom, $urandom};
    endcase
  endfunction

  task automatic drive_random();
    in_valid  = ($urandom % 100) < 80;
    flush     = ($urandom % 100) < 8;
    op        = mul_pkg::mul_fn_t'($urandom % 4);
    word      = (op == mul_pkg::FN_MUL) && (($urandom % 100) < 25);
    tag       = mul_pkg::tag_t'($urandom);
    operand_a = pick_operand();
    operand_b = pick_operand();
  endtask

  task automatic drive_idle();
    in_valid = 1'b0;
    flush    = 1'b0;
    word     = 1'b0;
  endtask

  // compare this cycle's outputs and then advance the slot past the next edge
  task automatic check_and_advance();
    logic exp_valid;
    exp_valid = pend_valid && !flush;
    if (out_valid !== exp_valid) begin
      $display("CHECK FAILED at %0t: out_valid expected %0b got %0b",
               $time, exp_valid, out_valid);
      errors++;
    end
    if (exp_valid && out_valid === 1'b1) begin
      results_seen++;
      if (out_tag !== pend_tag) begin
        $display("CHECK FAILED at %0t: out_tag expected %0h got %0h",
                 $time, pend_tag, out_tag);
        errors++;
      end
      if (result !== pend_result) begin
        $display("CHECK FAILED at %0t: result expected %016h got %016h",
                 $time, pend_result, result);
        errors++;
      end
    end
    if (pend_valid && flush) begin
      results_killed++;
    end
    if (in_valid && flush) begin
      offers_flushed++;   // must never show up later
    end
    if (in_valid && !flush) begin
      pend_valid  = 1'b1;
      pend_tag    = tag;
      pend_result = model_result(op, word, operand_a, operand_b);
    end else begin
      pend_valid = 1'b0;
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(46));
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    flush          = 1'b0;
    op             = mul_pkg::FN_MUL;
    word           = 1'b0;
    tag            = '0;
    operand_a      = '0;
    operand_b      = '0;
    pend_valid     = 1'b0;
    pend_tag       = '0;
    pend_result    = '0;
    errors         = 0;
    results_seen   = 0;
    offers_flushed = 0;
    results_killed = 0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("CHECK FAILED at %0t: out_valid expected 0 got %0b", $time, out_valid);
        errors++;
      end
    end
    rst_n = 1'b1;

    repeat (NUM_CYCLES) begin
      @(negedge clk);
      drive_random();
      #1;
      check_and_advance();
    end

    // let the last op come out
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      drive_idle();
      #1;
      check_and_advance();
    end

    $display("results %0d, flushed offers %0d, killed results %0d, errors %0d",
             results_seen, offers_flushed, results_killed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/mul_pkg.sv
rtl/mul_ctrl.sv
rtl/mul_pprod.sv
rtl/mul_accum.sv
rtl/mul_unit_top.sv
sim/tb_mul_unit.sv
